// File: Makefile
# Verilator build and run for the LETC memory side

VERILATOR ?= verilator
TOP       ?= letc_core_mem_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "all tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: rtl/letc_core_axi_fsm.sv
//LETC AXI read manager

`timescale 1ns/1ps

`include "letc_settings.svh"

module letc_core_axi_fsm (
    //Clock and reset
    input  logic                            i_clk,
    input  logic                            i_rst_n,

    //Fill requests from the caches
    input  logic [`LETC_NUM_PORTS-1:0]      i_limp_valid,
    input  letc_pkg::paddr_t                i_limp_addr [`LETC_NUM_PORTS],
    output logic [`LETC_NUM_PORTS-1:0]      o_limp_done,
    output letc_pkg::word_t                 o_limp_rdata,
    output logic                            o_limp_err,

    //AXI read address channel
    output logic                            o_axi_arvalid,
    input  logic                            i_axi_arready,
    output letc_pkg::paddr_t                o_axi_araddr,

    //AXI read data channel
    input  logic                            i_axi_rvalid,
    output logic                            o_axi_rready,
    input  letc_pkg::word_t                 i_axi_rdata,
    input  letc_pkg::axi_resp_t             i_axi_rresp
);

import letc_pkg::*;
import letc_core_pkg::*;

axi_state_e state_q;

//Port being served and port served last
port_idx_t grant_q;
port_idx_t last_q;

//Round robin result
logic [`LETC_NUM_PORTS-1:0] pending;
logic                       grant_valid;
port_idx_t                  grant_idx;

//A port whose done is pulsing still shows valid for that cycle
assign pending = i_limp_valid & ~o_limp_done;

//Search starts just after the last served port
always_comb begin
    int unsigned cand;
    grant_valid = 1'b0;
    grant_idx   = last_q;
    for (int i = 1; i <= `LETC_NUM_PORTS; i++) begin
        cand = (int'(last_q) + i) % `LETC_NUM_PORTS;
        if (!grant_valid && pending[cand]) begin
            grant_valid = 1'b1;
            grant_idx   = port_idx_t'(cand);
        end
    end
end

//Channel handshakes follow the state
assign o_axi_arvalid = (state_q == AXI_ADDR);
assign o_axi_rready  = (state_q == AXI_DATA);

//Transaction FSM
always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
        state_q     <= AXI_IDLE;
        grant_q     <= '0;
        last_q      <= '0;
        o_limp_done <= '0;
    end else begin
        o_limp_done <= '0;
        unique case (state_q)
            AXI_IDLE: begin
                if (grant_valid) begin
                    grant_q <= grant_idx;
                    state_q <= AXI_ADDR;
                end
            end
            AXI_ADDR: begin
                if (i_axi_arready) begin
                    state_q <= AXI_DATA;
                end
            end
            AXI_DATA: begin
                //Single beat, answer only the granted port
                if (i_axi_rvalid) begin
                    o_limp_done[grant_q] <= 1'b1;
                    last_q               <= grant_q;
                    state_q              <= AXI_IDLE;
                end
            end
            default: state_q <= AXI_IDLE;
        endcase
    end
end

//Address latched at grant, data at the R beat
always_ff @(posedge i_clk) begin
    if ((state_q == AXI_IDLE) && grant_valid) begin
        o_axi_araddr <= i_limp_addr[grant_idx];
    end
    if ((state_q == AXI_DATA) && i_axi_rvalid) begin
        o_limp_rdata <= i_axi_rdata;
        o_limp_err   <= (i_axi_rresp != AXI_RESP_OKAY);
    end
end

//One cache answered at a time
assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $onehot0(o_limp_done));

//AR payload held through back-pressure
assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_axi_arvalid && !i_axi_arready |=> $stable(o_axi_araddr));

endmodule : letc_core_axi_fsm

// File: rtl/letc_core_cache.sv
//LETC L1 read cache

`timescale 1ns/1ps

`include "letc_settings.svh"

module letc_core_cache (
    //Clock and reset
    input  logic                i_clk,
    input  logic                i_rst_n,

    //Invalidate all lines
    input  logic                i_flush,

    //Core side request
    input  logic                i_req,
    input  letc_pkg::paddr_t    i_addr,
    output letc_pkg::word_t     o_rdata,
    output logic                o_done,
    output logic                o_err,

    //Line fill request to the AXI manager
    output logic                o_limp_valid,
    output letc_pkg::paddr_t    o_limp_addr,
    input  logic                i_limp_done,
    input  letc_pkg::word_t     i_limp_rdata,
    input  logic                i_limp_err
);

import letc_pkg::*;
import letc_core_pkg::*;

//Line storage
logic       valid_q [`LETC_CACHE_LINES];
cache_tag_t tag_q   [`LETC_CACHE_LINES];
word_t      data_q  [`LETC_CACHE_LINES];

//Request being served
cache_state_e state_q;
logic         lookup_q;
paddr_t       req_addr_q;
cache_idx_t   req_idx;
cache_tag_t   req_tag;

logic accept;
logic hit;
logic fill_done;
logic fill_write;

//Split the held address into index and tag
assign req_idx = req_addr_q[CACHE_OFFSET_WIDTH +: CACHE_IDX_WIDTH];
assign req_tag = req_addr_q[`LETC_ADDR_WIDTH-1 -: CACHE_TAG_WIDTH];

//New request only when idle and not in the o_done cycle
assign accept = (state_q == CACHE_IDLE) && !lookup_q && !o_done && i_req;

//Tag compare happens the cycle after the request is taken
assign hit = valid_q[req_idx] && (tag_q[req_idx] == req_tag);

//Errors come back to the core but never allocate
assign fill_done  = (state_q == CACHE_FILL) && i_limp_done;
assign fill_write = fill_done && !i_limp_err;

//Fill address is the held request address
assign o_limp_addr = req_addr_q;

//Control FSM
always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
        state_q      <= CACHE_IDLE;
        lookup_q     <= 1'b0;
        o_done       <= 1'b0;
        o_err        <= 1'b0;
        o_limp_valid <= 1'b0;
    end else begin
        //Done and error are single-cycle
        o_done <= 1'b0;
        o_err  <= 1'b0;
        unique case (state_q)
            CACHE_IDLE: begin
                if (lookup_q) begin
                    lookup_q <= 1'b0;
                    if (hit) begin
                        o_done <= 1'b1;
                    end else begin
                        //On a miss ask the manager for the line
                        state_q      <= CACHE_FILL;
                        o_limp_valid <= 1'b1;
                    end
                end else if (accept) begin
                    lookup_q <= 1'b1;
                end
            end
            CACHE_FILL: begin
                if (i_limp_done) begin
                    state_q      <= CACHE_IDLE;
                    o_limp_valid <= 1'b0;
                    o_done       <= 1'b1;
                    o_err        <= i_limp_err;
                end
            end
            default: state_q <= CACHE_IDLE;
        endcase
    end
end

//Request address and returned word
always_ff @(posedge i_clk) begin
    if (accept) begin
        req_addr_q <= i_addr;
    end
    if (lookup_q && hit) begin
        o_rdata <= data_q[req_idx];
    end else if (fill_done) begin
        o_rdata <= i_limp_rdata;
    end
end

//Valid bits where a flush wins over a fill in the same cycle
always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
        for (int i = 0; i < `LETC_CACHE_LINES; i++) begin
            valid_q[i] <= 1'b0;
        end
    end else if (i_flush) begin
        for (int i = 0; i < `LETC_CACHE_LINES; i++) begin
            valid_q[i] <= 1'b0;
        end
    end else if (fill_write) begin
        valid_q[req_idx] <= 1'b1;
    end
end

//Tag and data arrays
always_ff @(posedge i_clk) begin
    if (fill_write) begin
        tag_q[req_idx]  <= req_tag;
        data_q[req_idx] <= i_limp_rdata;
    end
end

//Fill address held until the manager answers
assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_limp_valid |=> !o_limp_valid || $stable(o_limp_addr));

//A held request is answered once
assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_done && i_req |=> !o_done);

endmodule : letc_core_cache

// File: rtl/letc_core_mem_top.sv
//LETC memory side top

`timescale 1ns/1ps

`include "letc_settings.svh"

module letc_core_mem_top (
    //Clock and reset
    input  logic                            i_clk,
    input  logic                            i_rst_n,

    //Invalidate both caches
    input  logic                            i_flush,

    //Core side, one entry per port
    input  logic [`LETC_NUM_PORTS-1:0]      i_req,
    input  letc_pkg::paddr_t                i_addr [`LETC_NUM_PORTS],
    output letc_pkg::word_t                 o_rdata [`LETC_NUM_PORTS],
    output logic [`LETC_NUM_PORTS-1:0]      o_done,
    output logic [`LETC_NUM_PORTS-1:0]      o_err,

    //AXI read channels
    output logic                            o_axi_arvalid,
    input  logic                            i_axi_arready,
    output letc_pkg::paddr_t                o_axi_araddr,
    input  logic                            i_axi_rvalid,
    output logic                            o_axi_rready,
    input  letc_pkg::word_t                 i_axi_rdata,
    input  letc_pkg::axi_resp_t             i_axi_rresp
);

import letc_pkg::*;

//Cache to manager fill requests
logic [`LETC_NUM_PORTS-1:0] limp_valid;
paddr_t                     limp_addr [`LETC_NUM_PORTS];
logic [`LETC_NUM_PORTS-1:0] limp_done;

//Shared fill response, qualified by limp_done
word_t limp_rdata;
logic  limp_err;

//Port 0 is instruction, port 1 is data
for (genvar p = 0; p < `LETC_NUM_PORTS; p++) begin : gen_l1cache
    letc_core_cache l1cache (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_flush(i_flush),

        //Core side
        .i_req(i_req[p]),
        .i_addr(i_addr[p]),
        .o_rdata(o_rdata[p]),
        .o_done(o_done[p]),
        .o_err(o_err[p]),

        //Fill port
        .o_limp_valid(limp_valid[p]),
        .o_limp_addr(limp_addr[p]),
        .i_limp_done(limp_done[p]),
        .i_limp_rdata(limp_rdata),
        .i_limp_err(limp_err)
    );
end

letc_core_axi_fsm axi_fsm (
    .*,

    //Fill ports of all caches
    .i_limp_valid(limp_valid),
    .i_limp_addr(limp_addr),
    .o_limp_done(limp_done),
    .o_limp_rdata(limp_rdata),
    .o_limp_err(limp_err)
);

endmodule : letc_core_mem_top

// File: rtl/letc_core_pkg.sv
//LETC core internal types

`include "letc_settings.svh"

package letc_core_pkg;

//Index bits start above the byte offset within a word
localparam int CACHE_OFFSET_WIDTH = 2;
localparam int CACHE_IDX_WIDTH    = $clog2(`LETC_CACHE_LINES);
localparam int CACHE_TAG_WIDTH    = `LETC_ADDR_WIDTH - CACHE_IDX_WIDTH - CACHE_OFFSET_WIDTH;

//At least one bit even with a single port
localparam int PORT_IDX_WIDTH = (`LETC_NUM_PORTS > 1) ? $clog2(`LETC_NUM_PORTS) : 1;

//Line index into the cache arrays
typedef logic [CACHE_IDX_WIDTH-1:0] cache_idx_t;

//Address bits above the index
typedef logic [CACHE_TAG_WIDTH-1:0] cache_tag_t;

//Cache port number
typedef logic [PORT_IDX_WIDTH-1:0] port_idx_t;

//Cache FSM
typedef enum logic {
    CACHE_IDLE,
    CACHE_FILL
} cache_state_e;

//AXI read manager FSM
typedef enum logic [1:0] {
    AXI_IDLE,
    AXI_ADDR,
    AXI_DATA
} axi_state_e;

endpackage : letc_core_pkg

// File: rtl/letc_pkg.sv
//LETC common types

`include "letc_settings.svh"

package letc_pkg;

//One data word
typedef logic [`LETC_WORD_WIDTH-1:0] word_t;

//Byte address, low two bits always zero
typedef logic [`LETC_ADDR_WIDTH-1:0] paddr_t;

//AXI response code
typedef logic [1:0] axi_resp_t;

//Only OKAY counts as success
localparam axi_resp_t AXI_RESP_OKAY = 2'b00;

endpackage : letc_pkg

// File: rtl/letc_settings.svh
//LETC memory side settings

`ifndef LETC_SETTINGS_SVH
`define LETC_SETTINGS_SVH

//Data word width in bits
`define LETC_WORD_WIDTH 32

//Physical byte address width in bits
`define LETC_ADDR_WIDTH 32

//Lines per L1 cache, must be a power of two
`define LETC_CACHE_LINES 8

//Number of L1 caches (instruction and data)
`define LETC_NUM_PORTS 2

`endif

// File: sources.f
+incdir+rtl
rtl/letc_pkg.sv
rtl/letc_core_pkg.sv
rtl/letc_core_cache.sv
rtl/letc_core_axi_fsm.sv
rtl/letc_core_mem_top.sv
tb/letc_core_mem_model.sv
tb/letc_core_mem_tb.sv

// File: tb/letc_core_mem_model.sv
//AXI read slave model

`timescale 1ns/1ps

`include "letc_settings.svh"

module letc_core_mem_model (
    input  logic                    i_clk,
    input  logic                    i_rst_n,

    //Read address channel
    input  logic                    i_arvalid,
    output logic                    o_arready,
    input  letc_pkg::paddr_t        i_araddr,

    //Read data channel
    output logic                    o_rvalid,
    input  logic                    i_rready,
    output letc_pkg::word_t         o_rdata,
    output letc_pkg::axi_resp_t     o_rresp,

    //Accepted AR handshakes
    output integer                  o_read_count
);

import letc_pkg::*;

localparam logic [15:0] LFSR_SEED   = 16'd63591;
localparam axi_resp_t   RESP_SLVERR = 2'b10;

typedef enum logic [1:0] {
    MEM_IDLE,
    MEM_ADDR,
    MEM_DATA
} mem_state_e;

mem_state_e  state_q;
logic [1:0]  wait_q;
logic [15:0] lfsr_q;
logic [15:0] lfsr_one;
logic [15:0] lfsr_two;
logic [1:0]  delay;

//Taps 16 14 13 11, new bit enters at the bottom
function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
endfunction

//Two steps give the two bits of one delay
assign lfsr_one = lfsr_step(lfsr_q);
assign lfsr_two = lfsr_step(lfsr_one);
assign delay    = {lfsr_two[0], lfsr_one[0]};

always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
        state_q      <= MEM_IDLE;
        wait_q       <= '0;
        lfsr_q       <= LFSR_SEED;
        o_arready    <= 1'b0;
        o_rvalid     <= 1'b0;
        o_rdata      <= '0;
        o_rresp      <= '0;
        o_read_count <= 0;
    end else begin
        case (state_q)
            MEM_IDLE: begin
                //New AR seen, pick its latency
                if (i_arvalid) begin
                    wait_q  <= delay;
                    lfsr_q  <= lfsr_two;
                    state_q <= MEM_ADDR;
                end
            end
            MEM_ADDR: begin
                if (o_arready && i_arvalid) begin
                    o_arready    <= 1'b0;
                    o_read_count <= o_read_count + 1;
                    //Inverted address, bit 31 marks a slave error
                    o_rdata <= ~i_araddr;
                    o_rresp <= i_araddr[`LETC_ADDR_WIDTH-1] ? RESP_SLVERR : AXI_RESP_OKAY;
                    wait_q  <= delay;
                    lfsr_q  <= lfsr_two;
                    state_q <= MEM_DATA;
                end else if (wait_q == 2'd0) begin
                    o_arready <= 1'b1;
                end else begin
                    wait_q <= wait_q - 2'd1;
                end
            end
            default: begin
                //Single R beat, held until rready
                if (o_rvalid && i_rready) begin
                    o_rvalid <= 1'b0;
                    state_q  <= MEM_IDLE;
                end else if (wait_q == 2'd0) begin
                    o_rvalid <= 1'b1;
                end else begin
                    wait_q <= wait_q - 2'd1;
                end
            end
        endcase
    end
end

endmodule : letc_core_mem_model

// File: tb/letc_core_mem_tb.sv
//LETC memory side testbench

`timescale 1ns/1ps

`include "letc_settings.svh"

module letc_core_mem_tb;

import letc_pkg::*;

localparam int PERIOD      = 100;
localparam int DRIVE_DELAY = 1;
localparam int TIMEOUT     = 100;
localparam int NUM_ROWS    = 13;
localparam int NP          = `LETC_NUM_PORTS;

logic          clk;
logic          rst_n;
logic          flush;
logic [NP-1:0] req;
paddr_t        addr [NP];
word_t         rdata [NP];
logic [NP-1:0] done;
logic [NP-1:0] err;

//AXI read bus between DUT and model
logic      axi_arvalid;
logic      axi_arready;
paddr_t    axi_araddr;
logic      axi_rvalid;
logic      axi_rready;
word_t     axi_rdata;
axi_resp_t axi_rresp;
integer    read_count;

//Stimulus table, one entry per row
logic [NP-1:0] row_mask [NUM_ROWS];
paddr_t        row_addr [NUM_ROWS][NP];
logic          row_flush [NUM_ROWS];
logic          row_err [NUM_ROWS];
integer        row_reads [NUM_ROWS];

integer checks;
integer errors;
logic   timed_out;

letc_core_mem_top UUT (
    .i_clk(clk),
    .i_rst_n(rst_n),
    .i_flush(flush),
    .i_req(req),
    .i_addr(addr),
    .o_rdata(rdata),
    .o_done(done),
    .o_err(err),
    .o_axi_arvalid(axi_arvalid),
    .i_axi_arready(axi_arready),
    .o_axi_araddr(axi_araddr),
    .i_axi_rvalid(axi_rvalid),
    .o_axi_rready(axi_rready),
    .i_axi_rdata(axi_rdata),
    .i_axi_rresp(axi_rresp)
);

letc_core_mem_model mem_model (
    .i_clk(clk),
    .i_rst_n(rst_n),
    .i_arvalid(axi_arvalid),
    .o_arready(axi_arready),
    .i_araddr(axi_araddr),
    .o_rvalid(axi_rvalid),
    .i_rready(axi_rready),
    .o_rdata(axi_rdata),
    .o_rresp(axi_rresp),
    .o_read_count(read_count)
);

always #(PERIOD / 2) clk = ~clk;

task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
        $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        errors++;
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
        $display("Fail at %0t ns: %s is %b, expected %b", $time, name, got, exp);
        errors++;
    end
endtask

task automatic check_count(input string name, input integer got, input integer exp);
    checks++;
    if (got !== exp) begin
        $display("Fail at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
        errors++;
    end
endtask

task automatic set_row(input int i, input logic [NP-1:0] mask, input paddr_t a0,
                       input paddr_t a1, input logic fl, input logic er, input integer rd);
    row_mask[i]    = mask;
    row_addr[i][0] = a0;
    row_addr[i][1] = a1;
    row_flush[i]   = fl;
    row_err[i]     = er;
    row_reads[i]   = rd;
endtask

task automatic load_table();
    //First reads, one per port
    set_row(0, 2'b01, 32'h0000_1000, 32'h0, 1'b0, 1'b0, 1);
    set_row(1, 2'b10, 32'h0, 32'h0000_2004, 1'b0, 1'b0, 1);
    //Same addresses hit
    set_row(2, 2'b01, 32'h0000_1000, 32'h0, 1'b0, 1'b0, 0);
    set_row(3, 2'b10, 32'h0, 32'h0000_2004, 1'b0, 1'b0, 0);
    //Index 0 conflict evicts, then the old line misses again
    set_row(4, 2'b01, 32'h0000_3000, 32'h0, 1'b0, 1'b0, 1);
    set_row(5, 2'b01, 32'h0000_1000, 32'h0, 1'b0, 1'b0, 1);
    //Both ports at once, then both hit
    set_row(6, 2'b11, 32'h0000_4008, 32'h0000_5010, 1'b0, 1'b0, 2);
    set_row(7, 2'b11, 32'h0000_4008, 32'h0000_5010, 1'b0, 1'b0, 0);
    //Slave errors are never cached
    set_row(8, 2'b10, 32'h0, 32'h8000_0020, 1'b0, 1'b1, 1);
    set_row(9, 2'b10, 32'h0, 32'h8000_0020, 1'b0, 1'b1, 1);
    //Flush drops lines of both caches
    set_row(10, 2'b01, 32'h0000_1000, 32'h0, 1'b1, 1'b0, 1);
    set_row(11, 2'b10, 32'h0, 32'h0000_2004, 1'b0, 1'b0, 1);
    set_row(12, 2'b01, 32'h0000_1000, 32'h0, 1'b0, 1'b0, 0);
endtask

//Collect o_done of every requesting port
task automatic wait_done(input int row);
    logic [NP-1:0] seen;
    int            cycles;
    seen   = '0;
    cycles = 0;
    while (((seen & row_mask[row]) != row_mask[row]) && !timed_out) begin
        @(posedge clk);
        #DRIVE_DELAY;
        for (int p = 0; p < NP; p++) begin
            if (row_mask[row][p] && !seen[p] && done[p]) begin
                seen[p] = 1'b1;
                //Release the request in its done cycle
                req[p] = 1'b0;
                check_flag($sformatf("o_err[%0d]", p), err[p], row_err[row]);
                if (!row_err[row]) begin
                    check_word($sformatf("o_rdata[%0d]", p), rdata[p], ~row_addr[row][p]);
                end
            end
        end
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("Timeout in row %0d, a port never signalled done", row);
            errors++;
            timed_out = 1'b1;
        end
    end
endtask

task automatic run_row(input int row);
    integer reads_before;
    integer errors_before;
    errors_before = errors;
    @(posedge clk);
    #DRIVE_DELAY;
    //One cycle flush pulse with both caches idle
    if (row_flush[row]) begin
        flush = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        flush = 1'b0;
    end
    reads_before = read_count;
    for (int p = 0; p < NP; p++) begin
        addr[p] = row_addr[row][p];
        req[p]  = row_mask[row][p];
    end
    wait_done(row);
    check_count("bus reads", read_count - reads_before, row_reads[row]);
    if (errors == errors_before) begin
        $display("row %0d ok", row);
    end else begin
        $display("row %0d mismatch", row);
    end
endtask

initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    flush     = 1'b0;
    req       = '0;
    checks    = 0;
    errors    = 0;
    timed_out = 1'b0;
    for (int p = 0; p < NP; p++) begin
        addr[p] = '0;
    end
    load_table();
    //Reset held for two cycles
    repeat (2) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;
    for (int i = 0; i < NUM_ROWS && !timed_out; i++) begin
        run_row(i);
    end
    $display("rows %0d, checks %0d, errors %0d", NUM_ROWS, checks, errors);
    if (errors == 0 && !timed_out) begin
        $display("all tests passed");
    end else begin
        $display("tests failed");
    end
    $finish;
end

endmodule : letc_core_mem_tb
